// File: logic/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width
`define XLEN 32

// Data RAM size in 32-bit words
`define DMEM_WORDS 256
`define DMEM_ADDR_BITS 8

`endif

// File: logic/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

	// Where the writeback value comes from
	typedef enum logic [2:0] {
		SEL_ALU = 3'd0,
		SEL_MEM = 3'd1
	} wb_src_e;

	// Load and store widths, loads first
	typedef enum logic [2:0] {
		MEM_LB  = 3'd0,
		MEM_LH  = 3'd1,
		MEM_LW  = 3'd2,
		MEM_LBU = 3'd3,
		MEM_LHU = 3'd4,
		MEM_SB  = 3'd5,
		MEM_SH  = 3'd6,
		MEM_SW  = 3'd7
	} mem_op_e;

	localparam logic [`XLEN-1:0] CAUSE_DMEM_BUS_ERROR = `XLEN'd5;

endpackage

`default_nettype wire

// File: logic/axi_pkg.sv
`default_nettype none

package axi_pkg;

	// EXOKAY and DECERR are never produced here
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

endpackage

`default_nettype wire

// File: logic/ex_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module ex_issue (
	input	logic					clk,
	input	logic					reset,
	input	logic					flush,

	input	logic					in_valid,
	output	logic					in_ready,
	input	logic	[`XLEN-1:0]		in_pc,
	input	cpu_pkg::wb_src_e		in_wb_src,
	input	cpu_pkg::mem_op_e		in_mem_op,
	input	logic					in_rd_wena,
	input	logic	[4:0]			in_rd_addr,
	input	logic	[`XLEN-1:0]		in_addr,
	input	logic	[`XLEN-1:0]		in_store_data,
	input	logic	[`XLEN-1:0]		in_alu_result,

	output	logic					ex_valid,
	input	logic					ex_ready,
	output	logic	[`XLEN-1:0]		pc_ex,
	output	cpu_pkg::wb_src_e		wb_src_ex,
	output	cpu_pkg::mem_op_e		mem_op_ex,
	output	logic					rd_wena_ex,
	output	logic	[4:0]			rd_addr_ex,
	output	logic	[`XLEN-1:0]		alu_result_ex,

	output	logic	[`XLEN-1:0]		araddr,
	output	logic					arvalid,
	input	logic					arready,
	output	logic	[`XLEN-1:0]		awaddr,
	output	logic					awvalid,
	input	logic					awready,
	output	logic	[`XLEN-1:0]		wdata,
	output	logic					wvalid,
	output	logic	[3:0]			wstrb,
	input	logic					rvalid,
	input	logic					bvalid,
	output	logic					drain
);

	import cpu_pkg::*;

	logic				op_valid;
	logic				req_sent;	// Request already accepted by the RAM
	logic	[`XLEN-1:0]	addr_q;
	logic	[`XLEN-1:0]	store_data_q;
	logic				is_mem;
	logic				in_fire;
	logic				ex_fire;
	logic				req_fire;

	assign is_mem	= op_valid && wb_src_ex == SEL_MEM;
	assign ex_valid	= op_valid && !drain;
	assign ex_fire	= ex_valid && ex_ready;
	assign in_ready	= !drain && !flush && (!op_valid || ex_fire);
	assign in_fire	= in_valid && in_ready;

	assign araddr	= addr_q;
	assign awaddr	= addr_q;
	assign arvalid	= is_mem &&  rd_wena_ex && !req_sent;
	assign awvalid	= is_mem && !rd_wena_ex && !req_sent;
	assign wvalid	= awvalid;
	assign req_fire	= (arvalid && arready) || (awvalid && awready && wvalid);

	// Byte lanes follow the low address bits
	always_comb begin
		wdata = store_data_q << {addr_q[1:0], 3'b000};
		case (mem_op_ex)
			MEM_SB:		wstrb = 4'b0001 << addr_q[1:0];
			MEM_SH:		wstrb = 4'b0011 << addr_q[1:0];
			default:	wstrb = 4'b1111;
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			op_valid	<= 1'b0;
			req_sent	<= 1'b0;
			drain		<= 1'b0;
		end else begin
			if (drain && (rvalid || bvalid))
				drain <= 1'b0;	// mem_stage takes the stale response this cycle

			if (flush) begin
				op_valid	<= 1'b0;
				req_sent	<= 1'b0;
				if (is_mem && (req_sent || req_fire) && !ex_ready)
					drain <= 1'b1;
			end else if (in_fire) begin
				op_valid	<= 1'b1;
				req_sent	<= 1'b0;
			end else if (ex_fire) begin
				op_valid	<= 1'b0;
				req_sent	<= 1'b0;
			end else if (req_fire) begin
				req_sent	<= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			pc_ex			<= in_pc;
			wb_src_ex		<= in_wb_src;
			mem_op_ex		<= in_mem_op;
			rd_wena_ex		<= in_rd_wena;
			rd_addr_ex		<= in_rd_addr;
			alu_result_ex	<= in_alu_result;
			addr_q			<= in_addr;
			store_data_q	<= in_store_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/dmem_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module dmem_ram (
	input	logic					clk,
	input	logic					reset,

	input	logic	[`XLEN-1:0]		araddr,
	input	logic					arvalid,
	output	logic					arready,

	input	logic	[`XLEN-1:0]		awaddr,
	input	logic					awvalid,
	output	logic					awready,
	input	logic	[`XLEN-1:0]		wdata,
	input	logic					wvalid,
	input	logic	[3:0]			wstrb,

	output	logic	[`XLEN-1:0]		rdata,
	output	axi_pkg::axi_resp_e		rresp,
	output	logic					rvalid,
	input	logic					rready,

	output	axi_pkg::axi_resp_e		bresp,
	output	logic					bvalid,
	input	logic					bready
);

	import axi_pkg::*;

	logic	[`XLEN-1:0]	mem [`DMEM_WORDS];

	logic				ready_q;
	logic				rd_acc;
	logic				wr_acc;
	logic				rd_oob;
	logic				wr_oob;
	logic	[`DMEM_ADDR_BITS-1:0]	rd_idx;
	logic	[`DMEM_ADDR_BITS-1:0]	wr_idx;

	assign arready	= ready_q;
	assign awready	= ready_q;
	assign rd_acc	= arvalid && arready;
	assign wr_acc	= awvalid && awready && wvalid;

	assign rd_idx	= araddr[`DMEM_ADDR_BITS+1:2];
	assign wr_idx	= awaddr[`DMEM_ADDR_BITS+1:2];
	assign rd_oob	= araddr[`XLEN-1:2] >= `DMEM_WORDS;
	assign wr_oob	= awaddr[`XLEN-1:2] >= `DMEM_WORDS;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			ready_q	<= 1'b0;
			rvalid	<= 1'b0;
			bvalid	<= 1'b0;
		end else begin
			ready_q <= 1'b1;

			if (rd_acc)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			if (wr_acc)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Read data and responses are loaded at address acceptance
	always_ff @(posedge clk) begin
		if (rd_acc) begin
			rresp <= rd_oob ? SLVERR : OKAY;
			rdata <= rd_oob ? '0 : mem[rd_idx];
		end
		if (wr_acc) begin
			bresp <= wr_oob ? SLVERR : OKAY;
			if (!wr_oob) begin
				for (int b = 0; b < 4; b++) begin
					if (wstrb[b])
						mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module mem_stage (
	input	logic					clk,
	input	logic					reset,
	input	logic					flush,

	input	logic					ex_valid,
	output	logic					ex_ready,
	input	logic	[`XLEN-1:0]		pc_ex,
	input	cpu_pkg::wb_src_e		wb_src_ex,
	input	cpu_pkg::mem_op_e		mem_op_ex,
	input	logic					rd_wena_ex,
	input	logic	[4:0]			rd_addr_ex,
	input	logic	[`XLEN-1:0]		alu_result_ex,
	input	logic					drain,

	input	logic	[`XLEN-1:0]		araddr,
	input	logic	[`XLEN-1:0]		rdata,
	input	axi_pkg::axi_resp_e		rresp,
	input	logic					rvalid,
	output	logic					rready,
	input	axi_pkg::axi_resp_e		bresp,
	input	logic					bvalid,
	output	logic					bready,

	output	logic					wb_valid,
	input	logic					wb_ready,
	output	logic	[`XLEN-1:0]		wb_pc,
	output	logic					wb_rd_wena,
	output	logic	[4:0]			wb_rd_addr,
	output	logic	[`XLEN-1:0]		wb_rd_data,
	output	logic					wb_exc_pend,
	output	logic	[`XLEN-1:0]		wb_exc_cause
);

	import cpu_pkg::*;
	import axi_pkg::*;

	logic				is_mem;
	logic				is_load;
	logic				stall;
	logic				ex_fire;
	logic				capture;
	logic				bus_err;
	logic	[`XLEN-1:0]	rdata_aligned;
	logic	[`XLEN-1:0]	load_data;

	assign is_mem	= wb_src_ex == SEL_MEM;
	assign is_load	= is_mem && rd_wena_ex;
	assign stall	= is_mem && (rd_wena_ex ? !rvalid : !bvalid);	// Response not back yet

	assign ex_ready	= (!wb_valid || wb_ready) && !stall;
	assign ex_fire	= ex_valid && ex_ready;
	assign capture	= ex_fire && !flush;

	// Responses of flushed ops are taken and dropped while draining
	assign rready	= drain || (ex_fire && is_load);
	assign bready	= drain || (ex_fire && is_mem && !rd_wena_ex);

	assign bus_err	= is_mem && (rd_wena_ex ? rresp != OKAY : bresp != OKAY);

	assign rdata_aligned = rdata >> {araddr[1:0], 3'b000};

	always_comb begin
		case (mem_op_ex)
			MEM_LB:		load_data = {{24{rdata_aligned[7]}}, rdata_aligned[7:0]};
			MEM_LBU:	load_data = {24'h000000, rdata_aligned[7:0]};
			MEM_LH:		load_data = {{16{rdata_aligned[15]}}, rdata_aligned[15:0]};
			MEM_LHU:	load_data = {16'h0000, rdata_aligned[15:0]};
			default:	load_data = rdata_aligned;
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			wb_valid <= 1'b0;
		else if (flush)
			wb_valid <= 1'b0;
		else if (capture)
			wb_valid <= 1'b1;
		else if (wb_ready)
			wb_valid <= 1'b0;
	end

	// MEM/WB register, held while writeback stalls
	always_ff @(posedge clk) begin
		if (capture) begin
			wb_pc			<= pc_ex;
			wb_rd_addr		<= rd_addr_ex;
			wb_rd_wena		<= rd_wena_ex && !bus_err;
			wb_exc_pend		<= bus_err;
			wb_exc_cause	<= bus_err ? CAUSE_DMEM_BUS_ERROR : '0;
			if (is_load)
				wb_rd_data <= bus_err ? '0 : load_data;
			else
				wb_rd_data <= alu_result_ex;
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module mem_subsystem (
	input	logic					clk,
	input	logic					reset,
	input	logic					flush,

	input	logic					in_valid,
	output	logic					in_ready,
	input	logic	[`XLEN-1:0]		in_pc,
	input	cpu_pkg::wb_src_e		in_wb_src,
	input	cpu_pkg::mem_op_e		in_mem_op,
	input	logic					in_rd_wena,
	input	logic	[4:0]			in_rd_addr,
	input	logic	[`XLEN-1:0]		in_addr,
	input	logic	[`XLEN-1:0]		in_store_data,
	input	logic	[`XLEN-1:0]		in_alu_result,

	output	logic					wb_valid,
	input	logic					wb_ready,
	output	logic	[`XLEN-1:0]		wb_pc,
	output	logic					wb_rd_wena,
	output	logic	[4:0]			wb_rd_addr,
	output	logic	[`XLEN-1:0]		wb_rd_data,
	output	logic					wb_exc_pend,
	output	logic	[`XLEN-1:0]		wb_exc_cause
);

	import cpu_pkg::*;
	import axi_pkg::*;

	// Execute to MEM
	logic				ex_valid;
	logic				ex_ready;
	logic	[`XLEN-1:0]	pc_ex;
	wb_src_e			wb_src_ex;
	mem_op_e			mem_op_ex;
	logic				rd_wena_ex;
	logic	[4:0]		rd_addr_ex;
	logic	[`XLEN-1:0]	alu_result_ex;
	logic				drain;

	// Data bus
	logic	[`XLEN-1:0]	araddr;
	logic				arvalid;
	logic				arready;
	logic	[`XLEN-1:0]	awaddr;
	logic				awvalid;
	logic				awready;
	logic	[`XLEN-1:0]	wdata;
	logic				wvalid;
	logic	[3:0]		wstrb;
	logic	[`XLEN-1:0]	rdata;
	axi_resp_e			rresp;
	logic				rvalid;
	logic				rready;
	axi_resp_e			bresp;
	logic				bvalid;
	logic				bready;

	ex_issue i_ex_issue (.*);

	dmem_ram i_dmem_ram (.*);

	mem_stage i_mem_stage (.*);

endmodule

`default_nettype wire

// File: testbench/mem_subsystem_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_asserts (
	input	logic					clk,
	input	logic					reset,
	input	logic					wb_valid,
	input	logic					wb_ready,
	input	logic	[31:0]			wb_pc,
	input	logic	[31:0]			wb_rd_data,
	input	logic	[4:0]			wb_rd_addr,
	input	logic					wb_rd_wena,
	input	logic					wb_exc_pend,
	input	logic	[31:0]			wb_exc_cause,
	input	logic					arvalid,
	input	logic					arready,
	input	logic					awvalid,
	input	logic					awready,
	input	logic					wvalid,
	input	logic					rvalid,
	input	logic					rready,
	input	logic	[31:0]			rdata,
	input	axi_pkg::axi_resp_e		rresp,
	input	logic					bvalid,
	input	logic					bready,
	input	axi_pkg::axi_resp_e		bresp
);

	import axi_pkg::*;

	// Held writeback must not move while the sink stalls
	wb_stable: assert property (@(posedge clk) disable iff (reset)
		wb_valid && !wb_ready |=> $stable(wb_pc) && $stable(wb_rd_data)
			&& $stable(wb_rd_addr) && $stable(wb_rd_wena)
			&& $stable(wb_exc_pend) && $stable(wb_exc_cause))
		else $error("writeback fields changed during a stall");

	read_resp: assert property (@(posedge clk) disable iff (reset)
		arvalid && arready |=> rvalid)
		else $error("no read response after an accepted read");

	write_resp: assert property (@(posedge clk) disable iff (reset)
		awvalid && awready && wvalid |=> bvalid)
		else $error("no write response after an accepted write");

	r_owed: assert property (@(posedge clk) disable iff (reset)
		$rose(rvalid) |-> $past(arvalid && arready))
		else $error("read response without a request");

	b_owed: assert property (@(posedge clk) disable iff (reset)
		$rose(bvalid) |-> $past(awvalid && awready && wvalid))
		else $error("write response without a request");

	// A pending response stays put until it is taken
	r_held: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
		else $error("read response changed before it was taken");

	b_held: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response changed before it was taken");

endmodule

bind mem_subsystem mem_subsystem_asserts i_asserts (.*);

`default_nettype wire

// File: testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_mem_subsystem;

	import cpu_pkg::*;

	localparam int HALF = 50;
	localparam int SETTLE = 40;		// Sample point before the next rising edge
	localparam int MAX_CYCLES = 3000;
	localparam int MEM_BYTES = `DMEM_WORDS * 4;

	logic				clk;
	logic				reset;
	logic				flush;
	logic				in_valid;
	logic				in_ready;
	logic	[`XLEN-1:0]	in_pc;
	wb_src_e			in_wb_src;
	mem_op_e			in_mem_op;
	logic				in_rd_wena;
	logic	[4:0]		in_rd_addr;
	logic	[`XLEN-1:0]	in_addr;
	logic	[`XLEN-1:0]	in_store_data;
	logic	[`XLEN-1:0]	in_alu_result;
	logic				wb_valid;
	logic				wb_ready = 1'b1;
	logic	[`XLEN-1:0]	wb_pc;
	logic				wb_rd_wena;
	logic	[4:0]		wb_rd_addr;
	logic	[`XLEN-1:0]	wb_rd_data;
	logic				wb_exc_pend;
	logic	[`XLEN-1:0]	wb_exc_cause;

	logic	[7:0]		model [MEM_BYTES];	// Byte image of the RAM
	logic	[`XLEN-1:0]	exp_pc [$];
	logic	[`XLEN-1:0]	exp_data [$];
	logic	[`XLEN-1:0]	exp_cause [$];
	logic				exp_wena [$];
	logic				exp_exc [$];
	logic	[4:0]		exp_rd [$];
	logic				stall_en = 1'b0;
	int					errors = 0;
	int					checks = 0;
	int					tests = 0;
	int					cycles = 0;

	mem_subsystem i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	task automatic compare(input string what, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Drives wb_ready and takes each writeback in order
	always @(negedge clk) begin
		wb_ready = stall_en ? ($urandom_range(2) != 0) : 1'b1;
		#SETTLE;
		if (!reset && wb_valid && wb_ready) begin
			if (exp_pc.size() == 0) begin
				errors++;
				$display("unexpected writeback at %0t for pc %h", $time, wb_pc);
			end else begin
				compare("pc", wb_pc, exp_pc.pop_front());
				compare("rd_wena", 32'(wb_rd_wena), 32'(exp_wena.pop_front()));
				compare("rd_addr", 32'(wb_rd_addr), 32'(exp_rd.pop_front()));
				compare("rd_data", wb_rd_data, exp_data.pop_front());
				compare("exc_pend", 32'(wb_exc_pend), 32'(exp_exc.pop_front()));
				compare("exc_cause", wb_exc_cause, exp_cause.pop_front());
			end
		end
	end

	function automatic logic [`XLEN-1:0] load_value(input mem_op_e op, input int a);
		case (op)
			MEM_LB:		return {{24{model[a][7]}}, model[a]};
			MEM_LBU:	return {24'h000000, model[a]};
			MEM_LH:		return {{16{model[a+1][7]}}, model[a+1], model[a]};
			MEM_LHU:	return {16'h0000, model[a+1], model[a]};
			default:	return {model[a+3], model[a+2], model[a+1], model[a]};
		endcase
	endfunction

	// Starts and ends on a falling edge
	task automatic send_op(input wb_src_e src, input mem_op_e op, input logic [`XLEN-1:0] addr,
			input logic [`XLEN-1:0] data, input logic [4:0] rd, input logic want_wb);
		logic	is_mem;
		logic	is_load;
		logic	err;
		logic	ok;
		int		a;
		is_mem = src == SEL_MEM;
		is_load = is_mem && op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
		err = is_mem && addr >= MEM_BYTES;
		a = int'(addr);
		in_pc = in_pc + 4;
		in_wb_src = src;
		in_mem_op = op;
		in_rd_wena = is_mem ? is_load : rd[0];
		in_rd_addr = rd;
		in_addr = addr;
		in_store_data = data;
		in_alu_result = is_mem ? ~in_pc : data;
		in_valid = 1'b1;
		if (want_wb) begin
			exp_pc.push_back(in_pc);
			exp_rd.push_back(rd);
			exp_wena.push_back(in_rd_wena && !err);
			exp_exc.push_back(err);
			exp_cause.push_back(err ? 32'd5 : 32'd0);
			if (is_load)
				exp_data.push_back(err ? '0 : load_value(op, a));
			else
				exp_data.push_back(in_alu_result);
		end
		if (is_mem && !is_load && !err) begin
			model[a] = data[7:0];
			if (op != MEM_SB) begin
				model[a+1] = data[15:8];
			end
			if (op == MEM_SW) begin
				model[a+2] = data[23:16];
				model[a+3] = data[31:24];
			end
		end
		do begin
			#SETTLE;
			ok = in_ready;
			@(negedge clk);
		end while (!ok);
		in_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_pc.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		wait_idle();
		tests++;
		$display("test %s done, errors so far %0d", name, errors);
	endtask

	task automatic test_alu();
		for (int i = 0; i < 4; i++)
			send_op(SEL_ALU, MEM_LW, '0, $urandom, 5'(i + 1), 1'b1);
		finish_test("alu");
	endtask

	task automatic test_word();
		logic [`XLEN-1:0] a;
		for (int i = 0; i < 8; i++) begin
			a = 32'($urandom_range(`DMEM_WORDS - 1)) << 2;
			send_op(SEL_MEM, MEM_SW, a, $urandom, 5'd3, 1'b1);
			send_op(SEL_MEM, MEM_LW, a, '0, 5'(i + 4), 1'b1);
		end
		finish_test("word");
	endtask

	task automatic test_sub_word();
		logic [`XLEN-1:0] a;
		for (int off = 0; off < 4; off++) begin
			a = 32'h40 + 32'(off);
			send_op(SEL_MEM, MEM_SW, 32'h40, $urandom, 5'd1, 1'b1);
			send_op(SEL_MEM, MEM_SB, a, $urandom, 5'd2, 1'b1);
			send_op(SEL_MEM, MEM_LB, a, '0, 5'd5, 1'b1);
			send_op(SEL_MEM, MEM_LBU, a, '0, 5'd6, 1'b1);
			if (off % 2 == 0) begin
				send_op(SEL_MEM, MEM_SH, a, $urandom, 5'd2, 1'b1);
				send_op(SEL_MEM, MEM_LH, a, '0, 5'd7, 1'b1);
				send_op(SEL_MEM, MEM_LHU, a, '0, 5'd8, 1'b1);
			end
			send_op(SEL_MEM, MEM_LW, 32'h40, '0, 5'd9, 1'b1);
		end
		finish_test("sub_word");
	endtask

	task automatic test_bus_error();
		send_op(SEL_MEM, MEM_SW, 32'h10, $urandom, 5'd1, 1'b1);
		send_op(SEL_MEM, MEM_SW, MEM_BYTES + 32'h10, $urandom, 5'd2, 1'b1);
		send_op(SEL_MEM, MEM_SB, MEM_BYTES + 32'h11, $urandom, 5'd3, 1'b1);
		send_op(SEL_MEM, MEM_LW, MEM_BYTES + 32'h10, '0, 5'd4, 1'b1);
		send_op(SEL_MEM, MEM_LW, 32'h10, '0, 5'd5, 1'b1);	// Alias word must be untouched
		finish_test("bus_error");
	endtask

	task automatic test_backpressure();
		logic [`XLEN-1:0] a;
		for (int i = 0; i < 8; i++)
			send_op(SEL_MEM, MEM_SW, 32'h200 + 32'(i * 4), $urandom, 5'd1, 1'b1);
		stall_en = 1'b1;
		for (int i = 0; i < 24; i++) begin
			a = 32'h200 + 32'($urandom_range(7) * 4);
			case ($urandom_range(2))
				0:			send_op(SEL_ALU, MEM_LW, '0, $urandom, 5'(i), 1'b1);
				1:			send_op(SEL_MEM, MEM_SW, a, $urandom, 5'(i), 1'b1);
				default:	send_op(SEL_MEM, MEM_LW, a, '0, 5'(i), 1'b1);
			endcase
		end
		stall_en = 1'b0;
		finish_test("backpressure");
	endtask

	task automatic test_flush();
		send_op(SEL_MEM, MEM_SW, 32'h300, $urandom, 5'd1, 1'b0);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		send_op(SEL_MEM, MEM_LW, 32'h300, '0, 5'd2, 1'b0);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		send_op(SEL_MEM, MEM_LW, 32'h300, '0, 5'd3, 1'b1);
		send_op(SEL_ALU, MEM_LW, '0, $urandom, 5'd4, 1'b1);
		finish_test("flush");
	endtask

	initial begin
		void'($urandom(32'h8dab));
		reset = 1'b1;
		flush = 1'b0;
		in_valid = 1'b0;
		in_pc = 32'h1000;
		in_wb_src = SEL_ALU;
		in_mem_op = MEM_LW;
		in_rd_wena = 1'b0;
		in_rd_addr = '0;
		in_addr = '0;
		in_store_data = '0;
		in_alu_result = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		test_alu();
		test_word();
		test_sub_word();
		test_bus_error();
		test_backpressure();
		test_flush();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/cpu_pkg.sv
logic/axi_pkg.sv
logic/ex_issue.sv
logic/dmem_ram.sv
logic/mem_stage.sv
logic/mem_subsystem.sv
testbench/mem_subsystem_asserts.sv
testbench/tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench, status follows the final verdict line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_mem_subsystem -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^sim passed$" \
	&& exit 0 \
	|| exit 1
